//--- design/mem_pkg.sv
/*
 * Shared types and widths for the load/store memory path.
 * Imported by the request stage, request FIFO, access handler and top level.
 */

package mem_pkg;

    localparam int xlen      = 32;       // data and address width
    localparam int be_w      = xlen / 8; // one enable per byte lane
    localparam int lane_bits = 2;        // addr[1:0] picks the lane

    // access opcode, encoded as {store, func3}
    typedef enum logic [3:0] {
        op_lb  = 4'h0,
        op_lh  = 4'h1,
        op_lw  = 4'h2,
        op_lbu = 4'h4,
        op_lhu = 4'h5,
        op_sb  = 4'h8,
        op_sh  = 4'h9,
        op_sw  = 4'ha
    } mem_op_t;

    // handler slots, data then fetch
    typedef enum logic [1:0] {
        st_data       = 2'd0,
        st_data_wait  = 2'd1,
        st_fetch      = 2'd2,
        st_fetch_wait = 2'd3
    } handler_state_t;

    // true for the five load opcodes
    function automatic logic is_load_op(input mem_op_t op);
        logic is_ld;
        case (op)
            op_lb, op_lh, op_lw, op_lbu, op_lhu: is_ld = 1'b1;
            default:                             is_ld = 1'b0;
        endcase
        return is_ld;
    endfunction

endpackage

//--- design/lsu_request_stage.sv
/*
 * Front stage of the load/store path. Registers one core request, turns
 * req_store/func3 into an opcode and lines store data and byte enables up
 * with the addressed lane before handing the entry to the request FIFO.
 */
`timescale 1ns/100ps

module lsu_request_stage (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_store,
    input  logic [2:0]                req_func3,
    input  logic [mem_pkg::xlen-1:0]  req_addr,
    input  logic [mem_pkg::xlen-1:0]  req_wdata,
    output logic                      s_valid,
    input  logic                      s_ready,
    output mem_pkg::mem_op_t          s_op,
    output logic [mem_pkg::xlen-1:0]  s_addr,
    output logic [mem_pkg::xlen-1:0]  s_wdata,
    output logic [mem_pkg::be_w-1:0]  s_be
);
    import mem_pkg::*;

    mem_op_t              op_dec;
    logic [lane_bits-1:0] lane;
    logic [xlen-1:0]      wdata_lane;
    logic [be_w-1:0]      be_lane;

    assign lane = req_addr[lane_bits-1:0];

    // output register free, or being drained this cycle
    assign req_ready = !s_valid || s_ready;

    // decode, unknown codes fall back to word access
    always_comb begin
        case ({req_store, req_func3})
            4'b0_000: op_dec = op_lb;
            4'b0_001: op_dec = op_lh;
            4'b0_010: op_dec = op_lw;
            4'b0_100: op_dec = op_lbu;
            4'b0_101: op_dec = op_lhu;
            4'b1_000: op_dec = op_sb;
            4'b1_001: op_dec = op_sh;
            4'b1_010: op_dec = op_sw;
            default:  op_dec = req_store ? op_sw : op_lw;
        endcase
    end

    // lane alignment of store data and enables
    always_comb begin
        case (op_dec)
            op_sb: begin
                wdata_lane = req_wdata << {lane, 3'b000};
                be_lane    = 4'b0001 << lane;
            end
            op_sh: begin
                wdata_lane = req_wdata << {lane[1], 4'b0000}; // half lane only, addr[0] ignored
                be_lane    = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata_lane = req_wdata; // sw, loads cleared below
                be_lane    = 4'b1111;
            end
        endcase
        if (is_load_op(op_dec)) begin
            wdata_lane = '0; // loads carry no data
            be_lane    = '0;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            s_valid <= 1'b0;
        end else if (req_ready) begin
            s_valid <= req_valid; // load new entry or go empty
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            s_op    <= op_dec;
            s_addr  <= req_addr;
            s_wdata <= wdata_lane;
            s_be    <= be_lane;
        end
    end

endmodule

//--- design/lsu_request_fifo.sv
/*
 * Circular request buffer between the request stage and the access handler.
 * Holds fifo_depth decoded entries, valid/ready on both ports.
 */
`timescale 1ns/100ps

module lsu_request_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      s_valid,
    output logic                      s_ready,
    input  mem_pkg::mem_op_t          s_op,
    input  logic [mem_pkg::xlen-1:0]  s_addr,
    input  logic [mem_pkg::xlen-1:0]  s_wdata,
    input  logic [mem_pkg::be_w-1:0]  s_be,
    output logic                      q_valid,
    input  logic                      q_ready,
    output mem_pkg::mem_op_t          q_op,
    output logic [mem_pkg::xlen-1:0]  q_addr,
    output logic [mem_pkg::xlen-1:0]  q_wdata,
    output logic [mem_pkg::be_w-1:0]  q_be
);
    import mem_pkg::*;

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    mem_op_t         op_mem    [fifo_depth];
    logic [xlen-1:0] addr_mem  [fifo_depth];
    logic [xlen-1:0] wdata_mem [fifo_depth];
    logic [be_w-1:0] be_mem    [fifo_depth];

    logic [ptr_w-1:0] wr_ptr, rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push, pop;

    assign q_valid = (count != '0);
    // full is fine if the head leaves in the same cycle
    assign s_ready = (count != cnt_w'(fifo_depth)) || q_ready;
    assign push    = s_valid && s_ready;
    assign pop     = q_valid && q_ready;

    assign q_op    = op_mem[rd_ptr]; // head entry
    assign q_addr  = addr_mem[rd_ptr];
    assign q_wdata = wdata_mem[rd_ptr];
    assign q_be    = be_mem[rd_ptr];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // none, or both at once
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]    <= s_op;
            addr_mem[wr_ptr]  <= s_addr;
            wdata_mem[wr_ptr] <= s_wdata;
            be_mem[wr_ptr]    <= s_be;
        end
    end

endmodule

//--- design/mem_access_handler.sv
/*
 * Memory access handler. Alternates a data slot serving the request FIFO
 * with an instruction fetch slot at pc, waits out memory busy, and returns
 * sign/zero-extended load data or the fetched word as one-cycle pulses.
 */
`timescale 1ns/100ps

module mem_access_handler #(
    parameter int mem_words = 256
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          q_valid,
    output logic                          q_ready,
    input  mem_pkg::mem_op_t              q_op,
    input  logic [mem_pkg::xlen-1:0]      q_addr,
    input  logic [mem_pkg::xlen-1:0]      q_wdata,
    input  logic [mem_pkg::be_w-1:0]      q_be,
    input  logic [mem_pkg::xlen-1:0]      pc,
    output logic                          mem_req,
    output logic                          mem_we,
    output logic [mem_pkg::be_w-1:0]      mem_be,
    output logic [$clog2(mem_words)-1:0]  mem_word_addr,
    output logic [mem_pkg::xlen-1:0]      mem_wdata,
    input  logic                          mem_busy,
    input  logic [mem_pkg::xlen-1:0]      mem_rdata,
    output logic                          load_valid,
    output logic [mem_pkg::xlen-1:0]      load_data,
    output logic                          instr_valid,
    output logic [mem_pkg::xlen-1:0]      instruction
);
    import mem_pkg::*;

    localparam int addr_w = $clog2(mem_words);

    handler_state_t       state, state_nxt;
    mem_op_t              pend_op;   // op of data access in flight
    logic [lane_bits-1:0] pend_lane; // its byte offset
    logic                 start_data;
    logic                 data_done, fetch_done;
    logic [xlen-1:0]      byte_shift, half_shift, ext_data;

    // data access begins only with a queued request and an idle memory
    assign start_data = (state == st_data) && q_valid && !mem_busy;
    assign data_done  = (state == st_data_wait) && !mem_busy;
    assign fetch_done = (state == st_fetch_wait) && !mem_busy;
    assign q_ready    = start_data;

    always_comb begin
        state_nxt     = state;
        mem_req       = 1'b0;
        mem_we        = 1'b0;
        mem_be        = '0;
        mem_word_addr = q_addr[addr_w+1:2];
        mem_wdata     = q_wdata;
        case (state)
            st_data: begin
                if (start_data) begin
                    mem_req   = 1'b1;
                    mem_we    = !is_load_op(q_op);
                    mem_be    = q_be;
                    state_nxt = st_data_wait;
                end else if (!q_valid) begin
                    state_nxt = st_fetch; // nothing queued, skip slot
                end
            end
            st_data_wait:  if (!mem_busy) state_nxt = st_fetch;
            st_fetch: begin
                mem_word_addr = pc[addr_w+1:2]; // pc taken here
                if (!mem_busy) begin
                    mem_req   = 1'b1;
                    state_nxt = st_fetch_wait;
                end
            end
            st_fetch_wait: if (!mem_busy) state_nxt = st_data;
            default:       state_nxt = st_data;
        endcase
    end

    // lane select and extension of returned word
    always_comb begin
        byte_shift = mem_rdata >> {pend_lane, 3'b000};
        half_shift = mem_rdata >> {pend_lane[1], 4'b0000};
        case (pend_op)
            op_lb:   ext_data = {{24{byte_shift[7]}}, byte_shift[7:0]};
            op_lbu:  ext_data = {24'b0, byte_shift[7:0]};
            op_lh:   ext_data = {{16{half_shift[15]}}, half_shift[15:0]};
            op_lhu:  ext_data = {16'b0, half_shift[15:0]};
            default: ext_data = mem_rdata; // lw
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= st_data;
            load_valid  <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            state       <= state_nxt;
            load_valid  <= data_done && is_load_op(pend_op); // stores stay silent
            instr_valid <= fetch_done;
        end
    end

    always_ff @(posedge clk) begin
        if (start_data) begin
            pend_op   <= q_op;
            pend_lane <= q_addr[lane_bits-1:0];
        end
        if (data_done)  load_data   <= ext_data;
        if (fetch_done) instruction <= mem_rdata; // raw word
    end

endmodule

//--- design/word_memory.sv
/*
 * On-chip word memory with byte enables. Each accepted request keeps busy
 * high for wait_cycles cycles, busy drops as read data becomes valid.
 */
`timescale 1ns/100ps

module word_memory #(
    parameter int mem_words   = 256,
    parameter int wait_cycles = 2
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          mem_req,
    input  logic                          mem_we,
    input  logic [mem_pkg::be_w-1:0]      mem_be,
    input  logic [$clog2(mem_words)-1:0]  mem_word_addr,
    input  logic [mem_pkg::xlen-1:0]      mem_wdata,
    output logic                          mem_busy,
    output logic [mem_pkg::xlen-1:0]      mem_rdata
);
    import mem_pkg::*;

    localparam int addr_w = $clog2(mem_words);
    localparam int cnt_w  = (wait_cycles > 1) ? $clog2(wait_cycles) : 1;

    logic [xlen-1:0]   mem_array [mem_words];
    logic [cnt_w-1:0]  wait_cnt;
    logic              accept, do_access;
    logic              we_q;       // latched request
    logic [be_w-1:0]   be_q;
    logic [addr_w-1:0] addr_q;
    logic [xlen-1:0]   wdata_q;
    logic              acc_we;
    logic [be_w-1:0]   acc_be;
    logic [addr_w-1:0] acc_addr;
    logic [xlen-1:0]   acc_wdata;

    assign accept = mem_req && !mem_busy;

    // zero wait states access straight from the port
    always_comb begin
        if (wait_cycles == 0) begin
            do_access = accept;
            acc_we    = mem_we;
            acc_be    = mem_be;
            acc_addr  = mem_word_addr;
            acc_wdata = mem_wdata;
        end else begin
            do_access = mem_busy && (wait_cnt == '0); // last busy cycle
            acc_we    = we_q;
            acc_be    = be_q;
            acc_addr  = addr_q;
            acc_wdata = wdata_q;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mem_busy <= 1'b0;
            wait_cnt <= '0;
        end else if (accept && wait_cycles != 0) begin
            mem_busy <= 1'b1;
            wait_cnt <= cnt_w'(wait_cycles - 1);
        end else if (mem_busy) begin
            if (wait_cnt == '0) mem_busy <= 1'b0;
            else                wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            we_q    <= mem_we;
            be_q    <= mem_be;
            addr_q  <= mem_word_addr;
            wdata_q <= mem_wdata;
        end
        if (do_access && !acc_we) mem_rdata <= mem_array[acc_addr];
    end

    // array cleared at reset, byte-lane writes
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < mem_words; i++) mem_array[i] <= '0;
        end else if (do_access && acc_we) begin
            for (int b = 0; b < be_w; b++) begin
                if (acc_be[b]) mem_array[acc_addr][8*b +: 8] <= acc_wdata[8*b +: 8];
            end
        end
    end

endmodule

//--- design/mem_subsystem_top.sv
/*
 * Top of the memory access path: request stage, request FIFO, access
 * handler and word memory. Sets the sizing parameters for all of them.
 */
`timescale 1ns/100ps

module mem_subsystem_top #(
    parameter int fifo_depth  = 4,
    parameter int mem_words   = 256,
    parameter int wait_cycles = 2
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_store,
    input  logic [2:0]                req_func3,
    input  logic [mem_pkg::xlen-1:0]  req_addr,
    input  logic [mem_pkg::xlen-1:0]  req_wdata,
    input  logic [mem_pkg::xlen-1:0]  pc,
    output logic                      load_valid,
    output logic [mem_pkg::xlen-1:0]  load_data,
    output logic                      instr_valid,
    output logic [mem_pkg::xlen-1:0]  instruction
);
    import mem_pkg::*;

    // stage to fifo
    logic            s_valid, s_ready;
    mem_op_t         s_op;
    logic [xlen-1:0] s_addr, s_wdata;
    logic [be_w-1:0] s_be;

    // fifo to handler
    logic            q_valid, q_ready;
    mem_op_t         q_op;
    logic [xlen-1:0] q_addr, q_wdata;
    logic [be_w-1:0] q_be;

    // handler to memory
    logic                         mem_req, mem_we, mem_busy;
    logic [be_w-1:0]              mem_be;
    logic [$clog2(mem_words)-1:0] mem_word_addr;
    logic [xlen-1:0]              mem_wdata, mem_rdata;

    lsu_request_stage u_stage (
        .clk, .nrst,
        .req_valid, .req_ready, .req_store, .req_func3, .req_addr, .req_wdata,
        .s_valid, .s_ready, .s_op, .s_addr, .s_wdata, .s_be
    );

    lsu_request_fifo #(.fifo_depth(fifo_depth)) u_fifo (
        .clk, .nrst,
        .s_valid, .s_ready, .s_op, .s_addr, .s_wdata, .s_be,
        .q_valid, .q_ready, .q_op, .q_addr, .q_wdata, .q_be
    );

    mem_access_handler #(.mem_words(mem_words)) u_handler (
        .clk, .nrst,
        .q_valid, .q_ready, .q_op, .q_addr, .q_wdata, .q_be,
        .pc,
        .mem_req, .mem_we, .mem_be, .mem_word_addr, .mem_wdata,
        .mem_busy, .mem_rdata,
        .load_valid, .load_data, .instr_valid, .instruction
    );

    word_memory #(
        .mem_words  (mem_words),
        .wait_cycles(wait_cycles)
    ) u_mem (
        .clk, .nrst,
        .mem_req, .mem_we, .mem_be, .mem_word_addr, .mem_wdata,
        .mem_busy, .mem_rdata
    );

endmodule

//--- tb/mem_subsystem_assertions.sv
/*
 * Protocol checks on the access handler, attached to every
 * mem_access_handler instance by the bind at the end of this file.
 */
`timescale 1ns/100ps

module mem_subsystem_assertions (
    input logic                     clk,
    input logic                     nrst,
    input logic                     q_valid,
    input logic                     q_ready,
    input logic                     mem_req,
    input logic                     mem_busy,
    input logic                     load_valid,
    input logic                     instr_valid,
    input mem_pkg::handler_state_t  state
);
    import mem_pkg::*;

    // fifo pop only with an entry at the head
    q_ready_needs_valid: assert property (@(posedge clk) disable iff (!nrst)
        q_ready |-> q_valid)
        else $error("q_ready high while q_valid is low");

    // memory takes no new request while busy
    req_while_busy: assert property (@(posedge clk) disable iff (!nrst)
        mem_req |-> !mem_busy)
        else $error("mem_req raised while mem_busy is high");

    // one response per cycle toward the core
    single_response: assert property (@(posedge clk) disable iff (!nrst)
        !(load_valid && instr_valid))
        else $error("load_valid and instr_valid high together");

    // no request issued while waiting on memory
    quiet_in_wait: assert property (@(posedge clk) disable iff (!nrst)
        (state == st_data_wait || state == st_fetch_wait) |-> !mem_req)
        else $error("mem_req raised in a wait state");

endmodule

bind mem_access_handler mem_subsystem_assertions u_assertions (
    .clk        (clk),
    .nrst       (nrst),
    .q_valid    (q_valid),
    .q_ready    (q_ready),
    .mem_req    (mem_req),
    .mem_busy   (mem_busy),
    .load_valid (load_valid),
    .instr_valid(instr_valid),
    .state      (state)
);

//--- tb/mem_subsystem_tb.sv
/*
 * Testbench for the memory access path. Drives loads and stores on the core
 * port, keeps a byte-level reference memory and checks every load result
 * and fetched instruction against it. Run with the top module mem_subsystem_tb.
 */
`timescale 1ns/100ps

module mem_subsystem_tb;

    localparam int fifo_depth  = 4;
    localparam int mem_words   = 256;
    localparam int wait_cycles = 2;
    localparam int mem_bytes   = mem_words * 4;

    localparam logic [2:0] f3_b  = 3'd0; // func3 codes
    localparam logic [2:0] f3_h  = 3'd1;
    localparam logic [2:0] f3_w  = 3'd2;
    localparam logic [2:0] f3_bu = 3'd4;
    localparam logic [2:0] f3_hu = 3'd5;

    // request counts per test, sizes the watchdog
    localparam int n_word   = 8;
    localparam int n_fetch  = 8;
    localparam int n_burst  = 12;
    localparam int n_random = 400;
    localparam int test_requests   = 2 * n_word + 30 + 2 * n_fetch + n_burst + n_random + 8;
    localparam int watchdog_cycles = 50 * test_requests + 1000;

    logic        clk;
    logic        nrst;
    logic        req_valid;
    logic        req_ready;
    logic        req_store;
    logic [2:0]  req_func3;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [31:0] pc;
    logic        load_valid;
    logic [31:0] load_data;
    logic        instr_valid;
    logic [31:0] instruction;

    logic [7:0]  ref_mem [mem_bytes]; // byte image of the word memory
    logic [31:0] expected_q [$];      // load results in request order
    logic [31:0] exp_word;
    logic        saw_stall;           // req_valid seen with req_ready low
    int          loads_issued;
    int          loads_seen;

    mem_subsystem_top #(
        .fifo_depth (fifo_depth),
        .mem_words  (mem_words),
        .wait_cycles(wait_cycles)
    ) UUT (
        .clk, .nrst,
        .req_valid, .req_ready, .req_store, .req_func3, .req_addr, .req_wdata,
        .pc,
        .load_valid, .load_data, .instr_valid, .instruction
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Fail at %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
    endtask

    // aligned word at a byte address, upper address bits dropped
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr & (mem_bytes - 4));
        return {ref_mem[idx + 3], ref_mem[idx + 2], ref_mem[idx + 1], ref_mem[idx]};
    endfunction

    // load result as the ISA defines it
    function automatic logic [31:0] expected_load(input logic [2:0] func3,
                                                  input logic [31:0] addr);
        int          idx;
        int          hidx;
        logic [7:0]  b;
        logic [15:0] h;
        idx  = int'(addr & (mem_bytes - 1));
        hidx = idx & ~1; // halfword base
        b    = ref_mem[idx];
        h    = {ref_mem[hidx + 1], ref_mem[hidx]};
        case (func3)
            f3_b:    return {{24{b[7]}}, b};
            f3_h:    return {{16{h[15]}}, h};
            f3_bu:   return {24'b0, b};
            f3_hu:   return {16'b0, h};
            default: return ref_word(addr);
        endcase
    endfunction

    task automatic apply_store(input logic [2:0] func3, input logic [31:0] addr,
                               input logic [31:0] wdata);
        int idx;
        idx = int'(addr & (mem_bytes - 1));
        case (func3)
            f3_b: ref_mem[idx] = wdata[7:0]; // low byte lands in addressed lane
            f3_h: begin
                ref_mem[idx & ~1]       = wdata[7:0];
                ref_mem[(idx & ~1) + 1] = wdata[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) ref_mem[(idx & ~3) + i] = wdata[8*i +: 8];
            end
        endcase
    endtask

    // one request, held until req_ready, called at a falling edge
    task automatic issue(input logic store, input logic [2:0] func3,
                         input logic [31:0] addr, input logic [31:0] wdata);
        req_valid = 1'b1;
        req_store = store;
        req_func3 = func3;
        req_addr  = addr;
        req_wdata = wdata;
        while (!req_ready) begin
            saw_stall = 1'b1;
            @(negedge clk);
        end
        // transfer happens on the coming rising edge, in order
        if (store) begin
            apply_store(func3, addr, wdata);
        end else begin
            expected_q.push_back(expected_load(func3, addr));
            loads_issued++;
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // a trailing load returns only after all earlier stores are written
    task automatic drain_loads();
        int budget;
        issue(1'b0, f3_w, 32'h0, 32'h0);
        budget = 50 * (expected_q.size() + 1); // cycles allowed for the backlog
        while (expected_q.size() != 0 && budget > 0) begin
            @(posedge clk);
            budget--;
        end
        @(negedge clk);
    endtask

    // first fetch after the pc change may still use the old pc
    task automatic fetch_check(input logic [31:0] fetch_pc);
        pc = fetch_pc;
        do @(negedge clk); while (!instr_valid);
        do @(negedge clk); while (!instr_valid);
        check_value("instruction", ref_word(fetch_pc), instruction);
    endtask

    // load results in order, none lost or extra
    always @(negedge clk) begin
        if (nrst && load_valid) begin
            if (expected_q.size() == 0) begin
                abort_run($sformatf("Error at %0t: load_valid with no load outstanding", $time));
            end else begin
                exp_word = expected_q.pop_front();
                check_value("load_data", exp_word, load_data);
                loads_seen++;
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("Timeout: the run hung, no end after %0d cycles", watchdog_cycles));
    end

    initial begin
        logic        st;
        logic [2:0]  f3;
        logic [31:0] addr;
        logic [2:0]  load_codes [5];

        void'($urandom(84167));
        load_codes = '{f3_b, f3_h, f3_w, f3_bu, f3_hu};
        nrst      = 1'b0;
        req_valid = 1'b0;
        req_store = 1'b0;
        req_func3 = 3'd0;
        req_addr  = '0;
        req_wdata = '0;
        pc        = '0;
        saw_stall = 1'b0;
        loads_issued = 0;
        loads_seen   = 0;
        for (int i = 0; i < mem_bytes; i++) ref_mem[i] = 8'h00; // memory clears at reset

        repeat (8) @(negedge clk); // 8 cycles in reset
        check_value("load_valid", 32'd0, load_valid);
        check_value("instr_valid", 32'd0, instr_valid);
        nrst = 1'b1;
        repeat (2) @(negedge clk);

        // word round trip
        for (int i = 0; i < n_word; i++) issue(1'b1, f3_w, 32'h100 + 4 * i, $urandom());
        for (int i = 0; i < n_word; i++) issue(1'b0, f3_w, 32'h100 + 4 * i, 32'h0);
        drain_loads();

        // byte lanes over a known word
        for (int l = 0; l < 4; l++) begin
            issue(1'b1, f3_w, 32'h80, 32'h1234_5678);
            issue(1'b1, f3_b, 32'h80 + l, $urandom() | 32'h80); // sign bit set
            issue(1'b0, f3_w, 32'h80, 32'h0);                   // other lanes kept
            issue(1'b0, f3_b, 32'h80 + l, 32'h0);
            issue(1'b0, f3_bu, 32'h80 + l, 32'h0);
        end
        // half lanes
        for (int h = 0; h < 2; h++) begin
            issue(1'b1, f3_w, 32'h84, 32'h9abc_def0);
            issue(1'b1, f3_h, 32'h84 + 2 * h, $urandom() | 32'h8000);
            issue(1'b0, f3_w, 32'h84, 32'h0);
            issue(1'b0, f3_h, 32'h84 + 2 * h, 32'h0);
            issue(1'b0, f3_hu, 32'h84 + 2 * h, 32'h0);
        end
        drain_loads();

        // fetch from preloaded words, data queue idle
        for (int i = 0; i < n_fetch; i++) issue(1'b1, f3_w, 32'h200 + 4 * i, $urandom());
        drain_loads();
        for (int i = 0; i < n_fetch; i++) fetch_check(32'h200 + 4 * i);

        // burst with no gaps, fills the fifo
        saw_stall = 1'b0;
        for (int i = 0; i < n_burst / 2; i++) issue(1'b1, f3_w, 32'h40 + 4 * i, $urandom());
        for (int i = 0; i < n_burst / 2; i++) issue(1'b0, f3_w, 32'h40 + 4 * i, 32'h0);
        check_value("req_ready stall seen", 32'd1, saw_stall);
        drain_loads();

        // random mix over 16 words
        for (int n = 0; n < n_random; n++) begin
            st   = 1'($urandom_range(0, 1));
            f3   = st ? 3'($urandom_range(0, 2)) : load_codes[$urandom_range(0, 4)];
            addr = 32'($urandom_range(0, 63));
            if (f3[1:0] == 2'd1) addr = addr & ~32'h1; // aligned half
            if (f3[1:0] == 2'd2) addr = addr & ~32'h3; // aligned word
            issue(st, f3, addr, $urandom());
            repeat ($urandom_range(0, 3)) @(negedge clk);
        end
        drain_loads();

        if (expected_q.size() != 0 || loads_seen != loads_issued) begin
            $display("Error: %0d loads issued, %0d results seen", loads_issued, loads_seen);
            $display("Test failed");
            $fatal(1, "load count mismatch");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- sim.f
design/mem_pkg.sv
design/lsu_request_stage.sv
design/lsu_request_fifo.sv
design/mem_access_handler.sv
design/word_memory.sv
design/mem_subsystem_top.sv
tb/mem_subsystem_assertions.sv
tb/mem_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory path testbench with Verilator and runs it.
# Exit status is nonzero when the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=mem_subsystem_sim

if ! verilator --binary --timing --assert \
        --top-module mem_subsystem_tb \
        -f sim.f \
        --Mdir "$build_dir" \
        -o "$sim_bin"; then
    echo "verilator build failed"
    exit 1
fi

if ! "./$build_dir/$sim_bin"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without errors"
exit 0
